// File: include/vdma_config.svh
// Build-time sizes for the video DMA subsystem, included by the package and every RTL module
`ifndef VDMA_CONFIG_SVH
`define VDMA_CONFIG_SVH

// --------------------
// Bus and pixel word
// --------------------
// Pixel and bus word width
`define VDMA_DATA_W 16
// Frame RAM word address width
`define VDMA_ADRS_W 10

// --------------------
// Engine tuning
// --------------------
// Write FIFO depth in words, power of two
`define VDMA_FIFO_DEPTH 16
// Granted bus cycles before one forced idle cycle
`define VDMA_YIELD_CYCLES 8
// Frame RAM refresh period, ready low once per period
`define VDMA_RFSH_PERIOD 16

`endif

// File: hw/vdmaPkg.sv
// Shared port and bus types for the video DMA subsystem, referenced by scoped name
`include "vdma_config.svh"

package vdmaPkg;

	// --------------------
	// Pixel and bus words
	// --------------------
	// One data word with its valid flag
	// Used for pixel in, pixel out and RAM read data
	typedef struct packed {
		logic                    valid;
		logic [`VDMA_DATA_W-1:0] data;
	} pixWord;

	// Bus command from the engine to the frame RAM
	// write high means store wdata at adrs
	typedef struct packed {
		logic                    valid;
		logic                    write;
		logic [`VDMA_ADRS_W-1:0] adrs;
		logic [`VDMA_DATA_W-1:0] wdata;
	} ufiCmd;

	// --------------------
	// Host configuration
	// --------------------
	// Register index on the host port
	typedef enum logic [1:0] {
		cfgCtrl  = 2'd0,
		cfgBase0 = 2'd1,
		cfgBase1 = 2'd2,
		cfgLen   = 2'd3
	} cfgIdx;

	// One host write, held stable for a whole handshake
	typedef struct packed {
		cfgIdx                   idx;
		logic [`VDMA_DATA_W-1:0] value;
	} cfgWrite;

	// Register contents as seen by the engine
	typedef struct packed {
		logic                    en;
		logic [`VDMA_ADRS_W-1:0] base0;
		logic [`VDMA_ADRS_W-1:0] base1;
		logic [`VDMA_ADRS_W-1:0] frameLen;
	} dmaSettings;

endpackage

// File: hw/dmaFifo.sv
// Show-ahead write FIFO between the pixel producer and the DMA engine, head word always on rdData
`timescale 1ns/10ps
`include "vdma_config.svh"

module dmaFifo (
	input  logic                    iClk,
	input  logic                    rstN,
	// Producer side
	input  vdmaPkg::pixWord         wrData,
	output logic                    full,
	// Engine side
	output logic [`VDMA_DATA_W-1:0] rdData,
	input  logic                    re,
	output logic                    empty
);

	localparam int DataW = `VDMA_DATA_W;
	localparam int Depth = `VDMA_FIFO_DEPTH;
	localparam int PtrW  = $clog2(Depth);

	// --------------------
	// Storage and pointers
	// --------------------
	// Payload array, no reset
	logic [DataW-1:0] mem [Depth];
	// Extra top bit tells full from empty
	logic [PtrW:0]    wrPtr;
	logic [PtrW:0]    rdPtr;
	logic             wrEn;
	logic             rdEn;

	// Illegal accesses dropped here
	assign wrEn = wrData.valid && !full;
	assign rdEn = re && !empty;

	// --------------------
	// Flags
	// --------------------
	// Same index, wrap bits differ
	assign full  = (wrPtr[PtrW] != rdPtr[PtrW]) &&
		(wrPtr[PtrW-1:0] == rdPtr[PtrW-1:0]);
	// Pointers equal including wrap bit
	assign empty = (wrPtr == rdPtr);

	// Zero-latency head word
	assign rdData = mem[rdPtr[PtrW-1:0]];

	// Pointer update
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (wrEn)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			// Pop the head word once the engine has taken it
			if (rdEn)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

	// Payload write
	always_ff @(posedge iClk)
	begin
		if (wrEn)
		begin
			mem[wrPtr[PtrW-1:0]] <= wrData.data;
		end
	end

endmodule

// File: hw/dmaCfgRegs.sv
// Host register block of the video DMA, written over a four-phase req/ack handshake
`timescale 1ns/10ps
`include "vdma_config.svh"

module dmaCfgRegs (
	input  logic                iClk,
	input  logic                rstN,
	// Host port
	input  logic                cfgReq,
	input  vdmaPkg::cfgWrite    cfgWrite,
	output logic                cfgAck,
	// To the engine
	output vdmaPkg::dmaSettings settings
);

	localparam int AdrsW = `VDMA_ADRS_W;

	// --------------------
	// Register file
	// --------------------
	// Engine enable, bit 0 of the control word
	logic             enQ;
	// Buffer base addresses in words
	logic [AdrsW-1:0] base0Q;
	logic [AdrsW-1:0] base1Q;
	// Frame length in words
	logic [AdrsW-1:0] lenQ;
	// New request seen
	logic             reqTake;

	// Phase 1 of the handshake, req up and ack still down
	assign reqTake = cfgReq && !cfgAck;

	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			cfgAck <= 1'b0;
			enQ    <= 1'b0;
			base0Q <= '0;
			base1Q <= '0;
			lenQ   <= '0;
		end
		else if (reqTake)
		begin
			// Store once, ack up on the same edge
			cfgAck <= 1'b1;
			case (cfgWrite.idx)
				vdmaPkg::cfgCtrl:  enQ    <= cfgWrite.value[0];
				vdmaPkg::cfgBase0: base0Q <= cfgWrite.value[AdrsW-1:0];
				vdmaPkg::cfgBase1: base1Q <= cfgWrite.value[AdrsW-1:0];
				vdmaPkg::cfgLen:   lenQ   <= cfgWrite.value[AdrsW-1:0];
				default:           enQ    <= enQ;
			endcase
		end
		else if (!cfgReq && cfgAck)
		begin
			// Host dropped req, close the handshake
			cfgAck <= 1'b0;
		end
	end

	// --------------------
	// Settings out
	// --------------------
	// Engine samples these only while en is low
	assign settings = '{
		en:       enQ,
		base0:    base0Q,
		base1:    base1Q,
		frameLen: lenQ
	};

endmodule

// File: hw/videoDmaUnit.sv
// Ping-pong frame DMA engine, drains the write FIFO into one buffer while reading the other
`timescale 1ns/10ps
`include "vdma_config.svh"

module videoDmaUnit (
	input  logic                    iClk,
	input  logic                    rstN,
	input  vdmaPkg::dmaSettings     settings,
	// Write FIFO
	input  logic [`VDMA_DATA_W-1:0] fifoData,
	input  logic                    fifoEmpty,
	output logic                    fifoRe,
	// Pixel consumer
	input  logic                    pixRe,
	output vdmaPkg::pixWord         pixOut,
	// Frame RAM bus
	output vdmaPkg::ufiCmd          ufiCmd,
	input  logic                    ufiRdy,
	input  vdmaPkg::pixWord         ufiRsp,
	// Buffer role, 1 when base1 is written
	output logic                    bufSel
);

	localparam int AdrsW  = `VDMA_ADRS_W;
	localparam int DataW  = `VDMA_DATA_W;
	localparam int YieldW = $clog2(`VDMA_YIELD_CYCLES + 1);
	localparam logic [YieldW-1:0] YieldLast = YieldW'(`VDMA_YIELD_CYCLES);

	// --------------------
	// State
	// --------------------
	// Settings copy, taken while disabled
	logic [AdrsW-1:0]  base0Q;
	logic [AdrsW-1:0]  base1Q;
	logic [AdrsW-1:0]  lenQ;
	// Write and read pointers
	logic [AdrsW-1:0]  wrPtr;
	logic [AdrsW-1:0]  rdPtr;
	// Words still to go in this frame
	logic [AdrsW-1:0]  wrLeft;
	logic [AdrsW-1:0]  rdLeft;
	// Granted commands since the last idle slot
	logic [YieldW-1:0] yieldCnt;
	// Read data stage towards the consumer
	logic              outValid;
	logic [DataW-1:0]  outData;

	// --------------------
	// Arbitration
	// --------------------
	logic wrDone;
	logic rdDone;
	logic yieldNow;
	logic canIssue;
	logic rdGo;
	logic wrGo;
	logic swapNow;

	assign wrDone   = (wrLeft == '0);
	assign rdDone   = (rdLeft == '0);
	// Forced idle slot for other masters
	assign yieldNow = (yieldCnt == YieldLast);
	assign canIssue = settings.en && ufiRdy && !yieldNow;
	// Reads first
	assign rdGo     = canIssue && pixRe && !rdDone;
	// Writes only in a slot the reader left free
	assign wrGo     = canIssue && !rdGo && !fifoEmpty && !wrDone;
	// Both frames complete, roles flip
	assign swapNow  = settings.en && wrDone && rdDone && ufiRdy;

	// Bus command, live in the grant cycle
	assign ufiCmd = '{
		valid: rdGo || wrGo,
		write: wrGo,
		adrs:  wrGo ? wrPtr : rdPtr,
		wdata: fifoData
	};
	// FIFO pops the word that goes out on the bus
	assign fifoRe = wrGo;

	// --------------------
	// Pointers and roles
	// --------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			base0Q   <= '0;
			base1Q   <= '0;
			lenQ     <= '0;
			wrPtr    <= '0;
			rdPtr    <= '0;
			wrLeft   <= '0;
			rdLeft   <= '0;
			bufSel   <= 1'b0;
			yieldCnt <= '0;
		end
		else if (!settings.en)
		begin
			// Idle, track the host values
			base0Q   <= settings.base0;
			base1Q   <= settings.base1;
			lenQ     <= settings.frameLen;
			wrPtr    <= settings.base0;
			rdPtr    <= settings.base1;
			wrLeft   <= settings.frameLen;
			rdLeft   <= settings.frameLen;
			bufSel   <= 1'b0;
			yieldCnt <= '0;
		end
		else
		begin
			if (swapNow)
			begin
				// Writer moves to the buffer just read
				bufSel <= ~bufSel;
				wrPtr  <= bufSel ? base0Q : base1Q;
				rdPtr  <= bufSel ? base1Q : base0Q;
				wrLeft <= lenQ;
				rdLeft <= lenQ;
			end
			else
			begin
				if (wrGo)
				begin
					wrPtr  <= wrPtr + 1'b1;
					wrLeft <= wrLeft - 1'b1;
				end
				if (rdGo)
				begin
					rdPtr  <= rdPtr + 1'b1;
					rdLeft <= rdLeft - 1'b1;
				end
			end
			// Idle slot restarts the count
			if (yieldNow)
			begin
				yieldCnt <= '0;
			end
			else if (rdGo || wrGo)
			begin
				yieldCnt <= yieldCnt + 1'b1;
			end
		end
	end

	// --------------------
	// Pixel output
	// --------------------
	// Reads in flight still land after disable
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= ufiRsp.valid;
		end
	end

	always_ff @(posedge iClk)
	begin
		outData <= ufiRsp.data;
	end

	assign pixOut = '{valid: outValid, data: outData};

endmodule

// File: hw/frameRam.sv
// On-chip frame RAM acting as the bus slave, one-cycle read latency and a periodic refresh stall
`timescale 1ns/10ps
`include "vdma_config.svh"

module frameRam (
	input  logic            iClk,
	input  logic            rstN,
	input  vdmaPkg::ufiCmd  ufiCmd,
	output logic            ufiRdy,
	output vdmaPkg::pixWord ufiRsp
);

	localparam int AdrsW = `VDMA_ADRS_W;
	localparam int DataW = `VDMA_DATA_W;
	localparam int RfshW = $clog2(`VDMA_RFSH_PERIOD);
	localparam logic [RfshW-1:0] RfshLast = RfshW'(`VDMA_RFSH_PERIOD - 1);

	// --------------------
	// Array and read path
	// --------------------
	logic [DataW-1:0] mem [2**AdrsW];
	logic [DataW-1:0] rspData;
	logic             rspValid;
	logic [RfshW-1:0] rfshCnt;
	logic             cmdTake;

	// Commands only count while ready
	assign cmdTake = ufiCmd.valid && ufiRdy;

	// Refresh slot at the end of each period
	assign ufiRdy = (rfshCnt != RfshLast);

	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			rfshCnt  <= '0;
			rspValid <= 1'b0;
		end
		else
		begin
			rfshCnt  <= rfshCnt + 1'b1;
			// Read data valid one cycle after the command
			rspValid <= cmdTake && !ufiCmd.write;
		end
	end

	// Write and registered read, no reset on payload
	always_ff @(posedge iClk)
	begin
		if (cmdTake && ufiCmd.write)
		begin
			mem[ufiCmd.adrs] <= ufiCmd.wdata;
		end
		rspData <= mem[ufiCmd.adrs];
	end

	assign ufiRsp = '{valid: rspValid, data: rspData};

endmodule

// File: hw/videoDmaTop.sv
// Top of the video frame-buffer DMA, joins host registers, write FIFO, DMA engine and frame RAM
`timescale 1ns/10ps
`include "vdma_config.svh"

module videoDmaTop (
	input  logic             iClk,
	input  logic             rstN,
	// Host configuration port
	input  logic             cfgReq,
	input  vdmaPkg::cfgWrite cfgWrite,
	output logic             cfgAck,
	// Pixel producer
	input  vdmaPkg::pixWord  pixIn,
	output logic             pixFull,
	// Pixel consumer
	input  logic             pixRe,
	output vdmaPkg::pixWord  pixOut,
	// Buffer being written
	output logic             bufSel
);

	// --------------------
	// Internal wiring
	// --------------------
	vdmaPkg::dmaSettings     settings;
	logic [`VDMA_DATA_W-1:0] fifoData;
	logic                    fifoEmpty;
	logic                    fifoRe;
	vdmaPkg::ufiCmd          ufiCmd;
	logic                    ufiRdy;
	vdmaPkg::pixWord         ufiRsp;

	dmaCfgRegs cfgRegs0 (
		.iClk     (iClk),
		.rstN     (rstN),
		.cfgReq   (cfgReq),
		.cfgWrite (cfgWrite),
		.cfgAck   (cfgAck),
		.settings (settings)
	);

	// Absorbs bus stalls until pixFull rises
	dmaFifo fifo0 (
		.iClk   (iClk),
		.rstN   (rstN),
		.wrData (pixIn),
		.full   (pixFull),
		.rdData (fifoData),
		.re     (fifoRe),
		.empty  (fifoEmpty)
	);

	videoDmaUnit dmaUnit0 (
		.iClk      (iClk),
		.rstN      (rstN),
		.settings  (settings),
		.fifoData  (fifoData),
		.fifoEmpty (fifoEmpty),
		.fifoRe    (fifoRe),
		.pixRe     (pixRe),
		.pixOut    (pixOut),
		.ufiCmd    (ufiCmd),
		.ufiRdy    (ufiRdy),
		.ufiRsp    (ufiRsp),
		.bufSel    (bufSel)
	);

	frameRam ram0 (
		.iClk   (iClk),
		.rstN   (rstN),
		.ufiCmd (ufiCmd),
		.ufiRdy (ufiRdy),
		.ufiRsp (ufiRsp)
	);

endmodule

// File: verif/videoDma_assertions.sv
// Bus and pixel output protocol checks for the DMA engine, bound into every videoDmaUnit
`timescale 1ns/10ps

module videoDmaAssertions (
	input logic                iClk,
	input logic                rstN,
	input vdmaPkg::dmaSettings settings,
	input vdmaPkg::ufiCmd      ufiCmd,
	input logic                ufiRdy,
	input vdmaPkg::pixWord     pixOut
);

	// Read taken by the RAM this cycle
	logic rdIssued;

	assign rdIssued = ufiCmd.valid && !ufiCmd.write && ufiRdy;

	// --------------------
	// Bus rules
	// --------------------
	// Commands only in ready cycles
	cmdNeedsReady: assert property (@(posedge iClk) disable iff (!rstN)
		ufiCmd.valid |-> ufiRdy)
		else $error("bus command issued while ufiRdy is low");

	// Disabled engine stays off the bus
	cmdNeedsEnable: assert property (@(posedge iClk) disable iff (!rstN)
		ufiCmd.valid |-> settings.en)
		else $error("bus command issued while the engine is disabled");

	// --------------------
	// Output rule
	// --------------------
	// RAM latency one, output register one more
	outAfterRead: assert property (@(posedge iClk) disable iff (!rstN)
		pixOut.valid |-> $past(rdIssued, 2))
		else $error("pixOut valid without a read command two cycles before");

endmodule

bind videoDmaUnit videoDmaAssertions asrt0 (
	.iClk     (iClk),
	.rstN     (rstN),
	.settings (settings),
	.ufiCmd   (ufiCmd),
	.ufiRdy   (ufiRdy),
	.pixOut   (pixOut)
);

// File: verif/videoDmaTb.sv
// Simulation top that streams ping-pong frames through the video DMA and checks the frame delay
`timescale 1ns/10ps
`include "vdma_config.svh"

module videoDmaTb;

	localparam int DataW = `VDMA_DATA_W;
	localparam int Depth = `VDMA_FIFO_DEPTH;
	// Limit from the words read by all tests at four cycles each plus setup margin
	localparam int TimeoutCycles = (3*32 + 2*16 + 4*24 + 3*20) * 4 + 2000;

	logic             iClk;
	logic             rstN;
	logic             cfgReq;
	vdmaPkg::cfgWrite cfgWrite;
	logic             cfgAck;
	vdmaPkg::pixWord  pixIn;
	logic             pixFull;
	logic             pixRe;
	vdmaPkg::pixWord  pixOut;
	logic             bufSel;

	// Scoreboard of words pushed and not yet read back
	logic [DataW-1:0] sbQueue [$];
	int               errorCount;
	int               failedTests;
	int               testCount;
	int               cycleCount;

	videoDmaTop dut0 (
		.iClk     (iClk),
		.rstN     (rstN),
		.cfgReq   (cfgReq),
		.cfgWrite (cfgWrite),
		.cfgAck   (cfgAck),
		.pixIn    (pixIn),
		.pixFull  (pixFull),
		.pixRe    (pixRe),
		.pixOut   (pixOut),
		.bufSel   (bufSel)
	);

	// 10 ns clock
	initial
	begin
		iClk = 1'b0;
		forever #5 iClk = ~iClk;
	end

	// --------------------
	// Watchdog
	// --------------------
	initial
	begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge iClk);
			cycleCount++;
		end
		$display("Timeout: DUT still busy after %0d cycles", TimeoutCycles);
		$display("Test failed");
		$finish;
	end

	// Drive and sample point 1 ns after the edge
	task automatic nextCycle();
		@(posedge iClk);
		#1;
	endtask

	// --------------------
	// Compare tasks
	// --------------------
	task automatic checkPix(string name, vdmaPkg::pixWord got, vdmaPkg::pixWord exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkSel(logic got, logic exp);
		if (got !== exp)
		begin
			$display("FAILED bufSel: got %h, expected %h", got, exp);
			errorCount++;
		end
	endtask

	task automatic reportTest(string name, int errsBefore);
		testCount++;
		if (errorCount == errsBefore)
		begin
			$display("test %0d %s: ok", testCount, name);
		end
		else
		begin
			failedTests++;
			$display("test %0d %s: %0d errors", testCount, name, errorCount - errsBefore);
		end
	endtask

	// --------------------
	// Host and stream helpers
	// --------------------
	// One full four-phase register write
	task automatic hostWrite(vdmaPkg::cfgIdx idx, logic [DataW-1:0] value);
		cfgWrite = '{idx: idx, value: value};
		cfgReq = 1'b1;
		nextCycle();
		while (!cfgAck)
		begin
			nextCycle();
		end
		cfgReq = 1'b0;
		nextCycle();
		while (cfgAck)
		begin
			nextCycle();
		end
	endtask

	// Disable the engine and load all registers before the enable bit
	task automatic setupEngine(int base0, int base1, int len, logic en);
		hostWrite(vdmaPkg::cfgCtrl, '0);
		hostWrite(vdmaPkg::cfgBase0, DataW'(base0));
		hostWrite(vdmaPkg::cfgBase1, DataW'(base1));
		hostWrite(vdmaPkg::cfgLen, DataW'(len));
		hostWrite(vdmaPkg::cfgCtrl, {{(DataW-1){1'b0}}, en});
	endtask

	// Push words and collect frames+1 read frames with the first one from stale buffer data
	task automatic streamFrames(int frames, int len, int toPush, bit randomRe);
		int               pushed;
		int               seen;
		int               swaps;
		logic             lastSel;
		logic [DataW-1:0] word;
		pushed = 0;
		seen = 0;
		swaps = 0;
		lastSel = bufSel;
		fork
			// Producer that respects pixFull
			begin
				while (pushed < toPush)
				begin
					if (!pixFull)
					begin
						word = DataW'($urandom);
						pixIn = '{valid: 1'b1, data: word};
						sbQueue.push_back(word);
						pushed++;
					end
					else
					begin
						pixIn.valid = 1'b0;
					end
					nextCycle();
				end
				pixIn.valid = 1'b0;
			end
			// Consumer and swap monitor
			begin
				while (seen < (frames + 1) * len)
				begin
					nextCycle();
					if (bufSel != lastSel)
					begin
						swaps++;
					end
					lastSel = bufSel;
					if (pixOut.valid)
					begin
						if (seen >= len && sbQueue.size() == 0)
						begin
							$display("pixOut word %0d arrived with no written word to match", seen);
							errorCount++;
						end
						else if (seen >= len)
						begin
							checkPix("pixOut", pixOut, '{valid: 1'b1, data: sbQueue.pop_front()});
						end
						seen++;
					end
					pixRe = randomRe ? 1'($urandom) : 1'b1;
				end
				pixRe = 1'b0;
			end
		join
		if (swaps != frames)
		begin
			$display("saw %0d buffer swaps where %0d were expected", swaps, frames);
			errorCount++;
		end
		checkSel(bufSel, frames[0]);
		if (sbQueue.size() != 0)
		begin
			$display("%0d written words were never read back", sbQueue.size());
			errorCount++;
			sbQueue.delete();
		end
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic testResetAndHandshake();
		int errsBefore;
		errsBefore = errorCount;
		checkBit("cfgAck", cfgAck, 1'b0);
		checkBit("pixFull", pixFull, 1'b0);
		checkBit("pixOut.valid", pixOut.valid, 1'b0);
		checkSel(bufSel, 1'b0);
		// Ack rises one edge after req and holds while req stays up
		cfgWrite = '{idx: vdmaPkg::cfgBase0, value: '0};
		cfgReq = 1'b1;
		nextCycle();
		checkBit("cfgAck", cfgAck, 1'b1);
		nextCycle();
		checkBit("cfgAck", cfgAck, 1'b1);
		// Ack falls one edge after req drops
		cfgReq = 1'b0;
		nextCycle();
		checkBit("cfgAck", cfgAck, 1'b0);
		reportTest("reset and host handshake", errsBefore);
	endtask

	task automatic testPingPong();
		int errsBefore;
		errsBefore = errorCount;
		setupEngine(0, 512, 32, 1'b1);
		streamFrames(2, 32, 64, 1'b0);
		reportTest("ping-pong two frames", errsBefore);
	endtask

	task automatic testPreloadFull();
		int               errsBefore;
		logic [DataW-1:0] word;
		errsBefore = errorCount;
		setupEngine(0, 512, Depth, 1'b0);
		// Fill the FIFO while the engine is off
		for (int i = 0; i < Depth; i++)
		begin
			if (i == Depth - 1)
			begin
				checkBit("pixFull", pixFull, 1'b0);
			end
			word = DataW'($urandom);
			pixIn = '{valid: 1'b1, data: word};
			sbQueue.push_back(word);
			nextCycle();
		end
		pixIn.valid = 1'b0;
		checkBit("pixFull", pixFull, 1'b1);
		hostWrite(vdmaPkg::cfgCtrl, 'd1);
		streamFrames(1, Depth, 0, 1'b0);
		reportTest("full FIFO before enable", errsBefore);
	endtask

	task automatic testRandomGaps();
		int errsBefore;
		errsBefore = errorCount;
		setupEngine(0, 512, 24, 1'b1);
		streamFrames(3, 24, 72, 1'b1);
		reportTest("random pixRe gaps", errsBefore);
	endtask

	task automatic testReconfigure();
		int errsBefore;
		errsBefore = errorCount;
		hostWrite(vdmaPkg::cfgCtrl, '0);
		checkSel(bufSel, 1'b0);
		hostWrite(vdmaPkg::cfgBase0, 'd100);
		hostWrite(vdmaPkg::cfgBase1, 'd700);
		hostWrite(vdmaPkg::cfgLen, 'd20);
		checkSel(bufSel, 1'b0);
		hostWrite(vdmaPkg::cfgCtrl, 'd1);
		streamFrames(2, 20, 40, 1'b0);
		reportTest("reconfigure and re-enable", errsBefore);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		void'($urandom(32'hd289_b4da));
		errorCount = 0;
		failedTests = 0;
		testCount = 0;
		rstN = 1'b0;
		cfgReq = 1'b0;
		cfgWrite = '0;
		pixIn = '0;
		pixRe = 1'b0;
		repeat (10) @(posedge iClk);
		#1;
		rstN = 1'b1;
		testResetAndHandshake();
		testPingPong();
		testPreloadFull();
		testRandomGaps();
		testReconfigure();
		$display("%0d tests run, %0d with errors, %0d failed checks",
			testCount, failedTests, errorCount);
		if (errorCount == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+include
hw/vdmaPkg.sv
hw/dmaFifo.sv
hw/dmaCfgRegs.sv
hw/videoDmaUnit.sv
hw/frameRam.sv
hw/videoDmaTop.sv
verif/videoDma_assertions.sv
verif/videoDmaTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the video DMA testbench with Verilator; exit status follows the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir

verilator --binary --timing -Wno-fatal -f all.f --top-module videoDmaTb -o simv \
	> "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "Verilator build error"; exit 1; }

./obj_dir/simv > "$LOG" 2>&1 ; cat "$LOG"

grep -qx "Test passed" "$LOG" \
	&& { echo "Simulation result: PASS"; exit 0; } \
	|| { echo "Simulation result: FAIL"; exit 1; }
